/* design/icache_pkg.sv */
package icache_pkg;

    //////////////////////////////////////////////////////////////////////
    // cache geometry
    //////////////////////////////////////////////////////////////////////

    // 4 KiB total split as 64 sets of two 32-byte lines
    localparam int line_bytes = 32;
    localparam int set_count  = 64;
    localparam int offset_w   = $clog2(line_bytes);
    localparam int index_w    = $clog2(set_count);
    localparam int tag_w      = 32 - index_w - offset_w;
    localparam int line_w     = line_bytes * 8;
    // memory returns a line in four beats
    localparam int beat_w     = 64;
    // two banks per way
    localparam int bank_w     = line_w / 2;
    localparam int bank_count = 4;

    //////////////////////////////////////////////////////////////////////
    // shared types
    //////////////////////////////////////////////////////////////////////

    // lookup view of a fetch address
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } fetch_fields_t;

    // raw byte address for memory or split fields for lookup
    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_t fields;
    } fetch_addr_t;

    // request from the cpu port
    typedef struct packed {
        fetch_addr_t addr;
    } fetch_req_t;

    // strobes are active low, upper half of wdata feeds the odd bank
    typedef struct packed {
        logic [bank_count-1:0] cen;
        logic [bank_count-1:0] wen;
        logic [index_w-1:0]    addr;
        logic [line_w-1:0]     wdata;
        logic [line_w-1:0]     wmask;
    } sram_req_t;

endpackage

/* design/fetch_port.sv */
`timescale 1ns/1ps

module fetch_port (
    input  logic                   I_clk,
    input  logic                   I_rst,
    // four-phase cpu side
    input  logic                   cpu_req,
    input  logic [31:0]            cpu_addr,
    output logic                   cpu_ack,
    output logic [31:0]            cpu_inst,
    // pulse side towards the controller
    output logic                   req_valid,
    output icache_pkg::fetch_req_t req,
    input  logic                   rsp_valid,
    input  logic [31:0]            rsp_inst
);

    // one pass per transaction
    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_ack
    } port_state_t;

    port_state_t state;

    //////////////////////////////////////////////////////////////////////
    // handshake sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state     <= st_idle;
            req_valid <= 1'b0;
            cpu_ack   <= 1'b0;
        end else begin
            // pulse lasts one cycle only
            req_valid <= 1'b0;
            case (state)
                st_idle: begin
                    // new fetch once the previous ack is gone
                    if (cpu_req && !cpu_ack) begin
                        req_valid <= 1'b1;
                        state     <= st_wait;
                    end
                end
                st_wait: begin
                    // word comes back, raise ack
                    if (rsp_valid) begin
                        cpu_ack <= 1'b1;
                        state   <= st_ack;
                    end
                end
                st_ack: begin
                    // hold ack until the cpu lets go of req
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // address captured while idle, word held through the ack phase
    always_ff @(posedge I_clk) begin
        if (state == st_idle && cpu_req) begin
            req.addr.raw <= cpu_addr;
        end
        if (state == st_wait && rsp_valid) begin
            cpu_inst <= rsp_inst;
        end
    end

endmodule

/* design/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                          I_clk,
    input  logic                          I_rst,
    // fetch request and response
    input  logic                          req_valid,
    input  icache_pkg::fetch_req_t        req,
    output logic                          rsp_valid,
    output logic [31:0]                   rsp_inst,
    // data banks
    output icache_pkg::sram_req_t         sram,
    input  logic [icache_pkg::line_w-1:0] way0_rdata,
    input  logic [icache_pkg::line_w-1:0] way1_rdata,
    // memory read address channel
    output logic [31:0]                   mem_araddr,
    output logic                          mem_arvalid,
    input  logic                          mem_arready,
    // memory read data channel
    input  logic [icache_pkg::beat_w-1:0] mem_rdata,
    input  logic                          mem_rvalid,
    input  logic                          mem_rlast
);

    typedef enum logic [2:0] {
        st_idle,
        st_hit_ret,
        st_miss_req,
        st_reload,
        st_alloc
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    // tags per way
    logic [icache_pkg::tag_w-1:0]     tag0_tbl [icache_pkg::set_count];
    logic [icache_pkg::tag_w-1:0]     tag1_tbl [icache_pkg::set_count];
    // valid and round-robin bits, one per set
    logic [icache_pkg::set_count-1:0] valid0;
    logic [icache_pkg::set_count-1:0] valid1;
    logic [icache_pkg::set_count-1:0] rr_bit;

    icache_pkg::fetch_addr_t          lk_addr;
    icache_pkg::fetch_addr_t          addr_q;
    logic [icache_pkg::index_w-1:0]   idx_q;
    logic                             hit0;
    logic                             hit1;
    logic                             hit;
    logic                             hit_way_q;
    logic                             victim;
    logic [icache_pkg::line_w-1:0]    line_q;
    logic [icache_pkg::line_w-1:0]    rsp_line;
    logic [icache_pkg::offset_w-3:0]  word_sel;

    //////////////////////////////////////////////////////////////////////
    // tag lookup in the request cycle
    //////////////////////////////////////////////////////////////////////

    assign lk_addr = req.addr;

    assign hit0 = valid0[lk_addr.fields.index] &&
                  (tag0_tbl[lk_addr.fields.index] == lk_addr.fields.tag);
    assign hit1 = valid1[lk_addr.fields.index] &&
                  (tag1_tbl[lk_addr.fields.index] == lk_addr.fields.tag);
    assign hit  = hit0 || hit1;

    // request latched for the rest of the transaction
    always_ff @(posedge I_clk) begin
        if (state == st_idle && req_valid) begin
            addr_q    <= lk_addr;
            hit_way_q <= !hit0;
        end
    end

    assign idx_q = addr_q.fields.index;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    state_nxt = hit ? st_hit_ret : st_miss_req;
                end
            end
            // sram data is back, word goes out
            st_hit_ret: state_nxt = st_idle;
            // arvalid held until accepted
            st_miss_req: begin
                if (mem_arready) begin
                    state_nxt = st_reload;
                end
            end
            st_reload: begin
                if (mem_rvalid && mem_rlast) begin
                    state_nxt = st_alloc;
                end
            end
            // line written and word returned together
            st_alloc: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // burst read and line assembly
    //////////////////////////////////////////////////////////////////////

    assign mem_arvalid = (state == st_miss_req);
    // line aligned
    assign mem_araddr  = {addr_q.raw[31:icache_pkg::offset_w], {icache_pkg::offset_w{1'b0}}};

    // beats enter at the top, first beat ends up in the low bits
    always_ff @(posedge I_clk) begin
        if (state == st_reload && mem_rvalid) begin
            line_q <= {mem_rdata, line_q[icache_pkg::line_w-1:icache_pkg::beat_w]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // replacement and table update
    //////////////////////////////////////////////////////////////////////

    // empty way first, way 0 before way 1, else round robin
    always_comb begin
        if (!valid0[idx_q]) begin
            victim = 1'b0;
        end else if (!valid1[idx_q]) begin
            victim = 1'b1;
        end else begin
            victim = rr_bit[idx_q];
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid0 <= '0;
            valid1 <= '0;
            rr_bit <= '0;
        end else if (state == st_alloc) begin
            if (victim) begin
                valid1[idx_q] <= 1'b1;
            end else begin
                valid0[idx_q] <= 1'b1;
            end
            // flips on every fill into the set
            rr_bit[idx_q] <= ~rr_bit[idx_q];
        end
    end

    always_ff @(posedge I_clk) begin
        if (state == st_alloc) begin
            if (victim) begin
                tag1_tbl[idx_q] <= addr_q.fields.tag;
            end else begin
                tag0_tbl[idx_q] <= addr_q.fields.tag;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sram strobes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sram.cen   = '1;
        sram.wen   = '1;
        sram.addr  = idx_q;
        sram.wdata = line_q;
        sram.wmask = '1;
        if (state == st_idle && req_valid && hit) begin
            // read the hit way only
            sram.addr = lk_addr.fields.index;
            sram.cen  = hit0 ? 4'b1100 : 4'b0011;
        end else if (state == st_alloc) begin
            // full line write into the victim
            sram.cen   = victim ? 4'b0011 : 4'b1100;
            sram.wen   = victim ? 4'b0011 : 4'b1100;
            sram.wmask = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    assign rsp_valid = (state == st_hit_ret) || (state == st_alloc);

    // sram data on a hit, assembled line on a fill
    assign rsp_line = (state == st_hit_ret) ? (hit_way_q ? way1_rdata : way0_rdata) : line_q;
    assign word_sel = addr_q.fields.offset[icache_pkg::offset_w-1:2];
    assign rsp_inst = rsp_line[{word_sel, 5'b00000} +: 32];

endmodule

/* design/icache_data_ram.sv */
`timescale 1ns/1ps

module icache_data_ram (
    input  logic                          I_clk,
    input  icache_pkg::sram_req_t         sram,
    output logic [icache_pkg::line_w-1:0] way0_rdata,
    output logic [icache_pkg::line_w-1:0] way1_rdata
);

    //////////////////////////////////////////////////////////////////////
    // single-port banks
    //////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < icache_pkg::bank_count; b++) begin : g_bank
        logic [icache_pkg::bank_w-1:0] mem [icache_pkg::set_count];
        logic [icache_pkg::bank_w-1:0] wdata;
        logic [icache_pkg::bank_w-1:0] wmask;
        logic [icache_pkg::bank_w-1:0] rdata;

        // even bank takes the low half of the line
        assign wdata = sram.wdata[(b % 2) * icache_pkg::bank_w +: icache_pkg::bank_w];
        assign wmask = sram.wmask[(b % 2) * icache_pkg::bank_w +: icache_pkg::bank_w];

        always_ff @(posedge I_clk) begin
            if (!sram.cen[b]) begin
                if (!sram.wen[b]) begin
                    // mask bit low means write that bit
                    mem[sram.addr] <= (mem[sram.addr] & wmask) | (wdata & ~wmask);
                end else begin
                    // registered read
                    rdata <= mem[sram.addr];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // way mapping
    //////////////////////////////////////////////////////////////////////

    // way 0 on banks 0 and 1
    assign way0_rdata = {g_bank[1].rdata, g_bank[0].rdata};
    // way 1 on banks 2 and 3
    assign way1_rdata = {g_bank[3].rdata, g_bank[2].rdata};

endmodule

/* design/icache_top.sv */
`timescale 1ns/1ps

module icache_top (
    input  logic                          I_clk,
    input  logic                          I_rst,
    // cpu fetch port
    input  logic                          cpu_req,
    input  logic [31:0]                   cpu_addr,
    output logic                          cpu_ack,
    output logic [31:0]                   cpu_inst,
    // memory read channels
    output logic [31:0]                   mem_araddr,
    output logic                          mem_arvalid,
    input  logic                          mem_arready,
    input  logic [icache_pkg::beat_w-1:0] mem_rdata,
    input  logic                          mem_rvalid,
    input  logic                          mem_rlast
);

    // port to controller
    logic                          req_valid;
    icache_pkg::fetch_req_t        req;
    logic                          rsp_valid;
    logic [31:0]                   rsp_inst;
    // controller to banks
    icache_pkg::sram_req_t         sram;
    logic [icache_pkg::line_w-1:0] way0_rdata;
    logic [icache_pkg::line_w-1:0] way1_rdata;

    fetch_port fetch_port_i (
        .I_clk     (I_clk),
        .I_rst     (I_rst),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .cpu_ack   (cpu_ack),
        .cpu_inst  (cpu_inst),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_inst  (rsp_inst)
    );

    icache_ctrl icache_ctrl_i (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .req_valid   (req_valid),
        .req         (req),
        .rsp_valid   (rsp_valid),
        .rsp_inst    (rsp_inst),
        .sram        (sram),
        .way0_rdata  (way0_rdata),
        .way1_rdata  (way1_rdata),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast)
    );

    icache_data_ram icache_data_ram_i (
        .I_clk      (I_clk),
        .sram       (sram),
        .way0_rdata (way0_rdata),
        .way1_rdata (way1_rdata)
    );

endmodule

/* sim/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

    localparam int directed_fetches = 14;
    localparam int random_fetches   = 300;
    localparam int total_fetches    = directed_fetches + random_fetches;

    logic        I_clk = 1'b0;
    logic        I_rst;
    logic        cpu_req;
    logic [31:0] cpu_addr;
    logic        cpu_ack;
    logic [31:0] cpu_inst;
    logic [31:0] mem_araddr;
    logic        mem_arvalid;
    logic        mem_arready;
    logic [63:0] mem_rdata;
    logic        mem_rvalid;
    logic        mem_rlast;

    // expected results, oldest fetch first
    logic [31:0] exp_inst_q [$];
    logic        exp_miss_q [$];

    // mirror of tags, valid and round-robin bits
    logic [20:0] model_tag   [2][64];
    logic        model_valid [2][64];
    logic        model_rr    [64];

    int burst_count   = 0;
    int burst_at_req  = 0;
    int wait_cycles   = 0;

    icache_top icache_top_i (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_ack     (cpu_ack),
        .cpu_inst    (cpu_inst),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast)
    );

    always #10 I_clk = ~I_clk;

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // memory contents, address xor its own rotation by 13
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ {addr[18:0], addr[31:19]};
    endfunction

    // true on a miss, also performs the fill
    function automatic logic predict_miss(input logic [31:0] addr);
        logic [5:0]  idx;
        logic [20:0] tag;
        logic        way;
        idx = addr[10:5];
        tag = addr[31:11];
        if (model_valid[0][idx] && model_tag[0][idx] == tag) begin
            return 1'b0;
        end
        if (model_valid[1][idx] && model_tag[1][idx] == tag) begin
            return 1'b0;
        end
        // empty way first, then round robin
        if (!model_valid[0][idx]) begin
            way = 1'b0;
        end else if (!model_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = model_rr[idx];
        end
        model_valid[way][idx] = 1'b1;
        model_tag[way][idx]   = tag;
        model_rr[idx]         = ~model_rr[idx];
        return 1'b1;
    endfunction

    task automatic report_error(input string msg);
        $display("Test failures found");
        $fatal(1, "%s", msg);
    endtask

    //////////////////////////////////////////////////////////////////////
    // cpu driver, one four-phase transaction
    //////////////////////////////////////////////////////////////////////

    task automatic run_fetch(input logic [31:0] addr);
        int hold;
        exp_miss_q.push_back(predict_miss(addr));
        exp_inst_q.push_back(mem_word({addr[31:2], 2'b00}));
        @(posedge I_clk);
        cpu_addr <= addr;
        cpu_req  <= 1'b1;
        @(negedge I_clk);
        while (!cpu_ack) begin
            @(negedge I_clk);
        end
        // slow req drop, ack has to stay up
        hold = $urandom_range(0, 2);
        repeat (hold) @(posedge I_clk);
        @(posedge I_clk);
        cpu_req <= 1'b0;
        @(negedge I_clk);
        while (cpu_ack) begin
            @(negedge I_clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // memory responder
    //////////////////////////////////////////////////////////////////////

    task automatic check_ar_held(input logic [31:0] line_addr);
        assert (mem_arvalid)
            else report_error("arvalid dropped before the address handshake");
        assert (mem_araddr == line_addr)
            else report_error($sformatf("Mismatch at %0t: araddr moved to %h from %h",
                                        $time, mem_araddr, line_addr));
    endtask

    // beat k carries words 2k and 2k+1 of the line
    task automatic send_burst(input logic [31:0] line_addr);
        int gap;
        int k;
        for (k = 0; k < 4; k++) begin
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                @(posedge I_clk);
                mem_rvalid <= 1'b0;
                mem_rlast  <= 1'b0;
            end
            @(posedge I_clk);
            mem_rvalid <= 1'b1;
            mem_rlast  <= (k == 3);
            mem_rdata  <= {mem_word(line_addr + 8 * k + 4), mem_word(line_addr + 8 * k)};
        end
        @(posedge I_clk);
        mem_rvalid <= 1'b0;
        mem_rlast  <= 1'b0;
    endtask

    initial begin : memory_responder
        logic [31:0] line_addr;
        int          delay;
        mem_arready = 1'b0;
        mem_rdata   = '0;
        mem_rvalid  = 1'b0;
        mem_rlast   = 1'b0;
        forever begin
            @(negedge I_clk);
            if (!I_rst && mem_arvalid) begin
                line_addr = mem_araddr;
                assert (line_addr == {cpu_addr[31:5], 5'd0})
                    else report_error($sformatf("Mismatch at %0t: araddr %h for fetch %h",
                                                $time, line_addr, cpu_addr));
                // random arready delay, arvalid must hold
                delay = $urandom_range(0, 3);
                repeat (delay) begin
                    @(negedge I_clk);
                    check_ar_held(line_addr);
                end
                @(posedge I_clk);
                mem_arready <= 1'b1;
                @(negedge I_clk);
                check_ar_held(line_addr);
                // handshake edge
                @(posedge I_clk);
                mem_arready <= 1'b0;
                burst_count++;
                send_burst(line_addr);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response compare and protocol checks
    //////////////////////////////////////////////////////////////////////

    always @(negedge I_clk) begin : compare_responses
        logic        ack_prev;
        logic        req_prev;
        logic [31:0] inst_prev;
        logic [31:0] exp_inst;
        logic        exp_miss;
        if (I_rst) begin
            assert (!cpu_ack && !mem_arvalid)
                else report_error("ack or arvalid is high during reset");
            ack_prev = 1'b0;
            req_prev = 1'b0;
        end else begin
            // latency counted from the first cycle req is high
            if (cpu_req && !req_prev) begin
                wait_cycles  = 0;
                burst_at_req = burst_count;
            end else if (cpu_req) begin
                wait_cycles++;
            end
            if (cpu_ack && !ack_prev) begin
                assert (cpu_req) else report_error("ack rose while req was low");
                exp_inst = exp_inst_q.pop_front();
                exp_miss = exp_miss_q.pop_front();
                assert (cpu_inst == exp_inst)
                    else report_error($sformatf("Mismatch at %0t: inst %h, expected %h",
                                                $time, cpu_inst, exp_inst));
                assert ((burst_count - burst_at_req) == (exp_miss ? 1 : 0))
                    else report_error($sformatf("Mismatch at %0t: %0d bursts, miss expected %0d",
                                                $time, burst_count - burst_at_req, exp_miss));
                // hit timing is fixed
                if (!exp_miss) begin
                    assert (wait_cycles == 3)
                        else report_error($sformatf("Mismatch at %0t: hit ack after %0d cycles",
                                                    $time, wait_cycles));
                end
            end
            if (ack_prev && !cpu_ack) begin
                assert (!req_prev) else report_error("ack dropped while req was still high");
            end
            if (ack_prev && cpu_ack) begin
                assert (cpu_inst == inst_prev)
                    else report_error($sformatf("Mismatch at %0t: inst changed during ack",
                                                $time));
            end
            ack_prev = cpu_ack;
            req_prev = cpu_req;
        end
        inst_prev = cpu_inst;
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        repeat (total_fetches * 40 + 200) @(posedge I_clk);
        report_error("watchdog timeout, the fetch sequence did not finish");
    end

    initial begin : main_sequence
        int i;
        I_rst    = 1'b1;
        cpu_req  = 1'b0;
        cpu_addr = '0;
        void'($urandom(32'h057b_f2f8));
        for (i = 0; i < 64; i++) begin
            model_valid[0][i] = 1'b0;
            model_valid[1][i] = 1'b0;
            model_rr[i]       = 1'b0;
        end
        repeat (5) @(posedge I_clk);
        I_rst <= 1'b0;
        // cold misses
        run_fetch(32'h0000_1004);
        run_fetch(32'h0000_2018);
        run_fetch(32'h8000_003c);
        // hits in resident lines
        run_fetch(32'h0000_1000);
        run_fetch(32'h0000_101c);
        run_fetch(32'h0000_2008);
        // three tags fighting over set 5
        run_fetch(32'h0001_00a0);
        run_fetch(32'h0002_08a4);
        run_fetch(32'h0003_10b8);
        run_fetch(32'h0001_00a0);
        run_fetch(32'h0003_10b8);
        run_fetch(32'h0002_08a4);
        run_fetch(32'h0001_00a0);
        run_fetch(32'h0003_10b8);
        // four tags per set over all sets and offsets
        repeat (random_fetches) begin
            run_fetch(32'h0040_0000 | ($urandom() & 32'h0000_1fff));
        end
        repeat (4) @(posedge I_clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* filelist.f */
design/icache_pkg.sv
design/fetch_port.sv
design/icache_ctrl.sv
design/icache_data_ram.sv
design/icache_top.sv
sim/icache_tb.sv

/* Makefile */
# Verilator build and run of the instruction cache testbench
SIM := obj_dir/icache_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

# a failing run ends in $$fatal, so make sees a nonzero exit status
test:
	verilator --binary --timing --assert -j 0 --top-module icache_tb \
		-f filelist.f -o icache_sim
	./$(SIM)

clean:
	rm -rf obj_dir
